// ==== dual_sd_adc_pkg.sv ====
`default_nettype none

package dual_sd_adc_pkg;

    // Width of one decimated sample.
    localparam int SAMPLE_W = 8;

    // Decimation window, in clocks.
    localparam int WINDOW_LEN = 256;
    localparam int WINDOW_W = 8;

    // PWM counter and duty width.
    localparam int PWM_W = 8;

    // Bits per SPI transfer.
    localparam int SPI_BITS = 8;

    // UART bit time in clocks.
    // One dump line of five characters takes 200 clocks, well inside a window.
    localparam int CLKS_PER_BIT = 4;

    // Characters per dump line: four hex digits and a line feed.
    localparam int UART_CHARS = 5;

endpackage

`default_nettype wire

// ==== sd_digitizer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sd_digitizer
    import dual_sd_adc_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                i_reset,
    input  wire logic                i_lvds,
    output logic                     o_comp,
    output logic [SAMPLE_W-1:0]      o_sample,
    output logic                     o_sample_stb
);

    logic                comp_meta;
    logic [WINDOW_W-1:0] win_cnt;
    logic [SAMPLE_W-1:0] acc;
    logic [SAMPLE_W:0]   sum;
    logic                win_last;

    // Two-stage synchronizer; the second stage also drives the RC feedback.
    always_ff @(posedge clk) begin
        comp_meta <= i_lvds;
        o_comp    <= comp_meta;
    end

    assign win_last = (win_cnt == WINDOW_W'(WINDOW_LEN - 1));
    assign sum      = {1'b0, acc} + (SAMPLE_W + 1)'(o_comp);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            win_cnt      <= '0;
            acc          <= '0;
            o_sample_stb <= 1'b0;
        end else begin
            win_cnt      <= win_cnt + 1'b1;
            o_sample_stb <= win_last;
            if (win_last) begin
                acc <= '0;
            end else begin
                acc <= sum[SAMPLE_W-1:0];
            end
        end
    end

    // A window of all ones saturates.
    always_ff @(posedge clk) begin
        if (win_last) begin
            o_sample <= sum[SAMPLE_W] ? '1 : sum[SAMPLE_W-1:0];
        end
    end

    a_stb_on_wrap: assert property (@(posedge clk) disable iff (i_reset)
        o_sample_stb |-> win_cnt == '0);

    // Ones seen so far can never outnumber the clocks elapsed in the window.
    a_acc_bound: assert property (@(posedge clk) disable iff (i_reset)
        acc <= win_cnt);

endmodule

`default_nettype wire

// ==== spi_setpoint_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_setpoint_rx
    import dual_sd_adc_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                i_reset,
    input  wire logic                i_spi_sck,
    input  wire logic                i_spi_cs_n,
    input  wire logic                i_spi_mosi,
    output logic                     o_spi_miso,
    output logic [SPI_BITS-1:0]      o_setpoint,
    output logic                     o_setpoint_stb
);

    logic [1:0]                  sck_sync;
    logic [1:0]                  cs_sync;
    logic [1:0]                  mosi_sync;
    logic                        sck_q;
    logic                        cs_q;
    logic                        sck_rise;
    logic                        sck_fall;
    logic                        cs_fall;
    logic                        cs_low;
    logic [SPI_BITS-1:0]         rx_shift;
    logic [SPI_BITS-1:0]         tx_shift;
    logic [$clog2(SPI_BITS)-1:0] bit_cnt;

    // Synchronizers start from the bus idle levels.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            sck_sync <= 2'b00;
            cs_sync  <= 2'b11;
            sck_q    <= 1'b0;
            cs_q     <= 1'b1;
        end else begin
            sck_sync <= {sck_sync[0], i_spi_sck};
            cs_sync  <= {cs_sync[0], i_spi_cs_n};
            sck_q    <= sck_sync[1];
            cs_q     <= cs_sync[1];
        end
    end

    always_ff @(posedge clk) begin
        mosi_sync <= {mosi_sync[0], i_spi_mosi};
    end

    assign sck_rise = sck_sync[1] & ~sck_q;
    assign sck_fall = ~sck_sync[1] & sck_q;
    assign cs_fall  = ~cs_sync[1] & cs_q;
    assign cs_low   = ~cs_sync[1];

    // Receive path, MSB first. Partial bytes are dropped when CS rises.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            bit_cnt        <= '0;
            o_setpoint     <= '0;
            o_setpoint_stb <= 1'b0;
        end else begin
            o_setpoint_stb <= 1'b0;
            if (!cs_low) begin
                bit_cnt <= '0;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == $clog2(SPI_BITS)'(SPI_BITS - 1)) begin
                    o_setpoint     <= {rx_shift[SPI_BITS-2:0], mosi_sync[1]};
                    o_setpoint_stb <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cs_low && sck_rise) begin
            rx_shift <= {rx_shift[SPI_BITS-2:0], mosi_sync[1]};
        end
    end

    // Echo of the previous byte, loaded at CS fall and shifted on falling SCK.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            tx_shift <= '0;
        end else if (cs_fall) begin
            tx_shift <= o_setpoint;
        end else if (cs_low && sck_fall) begin
            tx_shift <= {tx_shift[SPI_BITS-2:0], 1'b0};
        end
    end

    assign o_spi_miso = tx_shift[SPI_BITS-1];

    a_stb_single: assert property (@(posedge clk) disable iff (i_reset)
        o_setpoint_stb |=> !o_setpoint_stb);

endmodule

`default_nettype wire

// ==== pwm_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwm_tracker
    import dual_sd_adc_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                i_reset,
    input  wire logic [SPI_BITS-1:0] i_setpoint,
    input  wire logic                i_setpoint_stb,
    input  wire logic [SAMPLE_W-1:0] i_sample,
    input  wire logic                i_sample_stb,
    output logic                     o_pwm,
    output logic                     o_locked
);

    logic [SPI_BITS-1:0] setpoint;
    logic [PWM_W-1:0]    duty;
    logic [PWM_W-1:0]    pwm_cnt;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            setpoint <= '0;
        end else if (i_setpoint_stb) begin
            setpoint <= i_setpoint;
        end
    end

    // One duty step per channel-0 sample, clamped at both ends.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            duty     <= '0;
            o_locked <= 1'b0;
        end else if (i_sample_stb) begin
            o_locked <= (i_sample == setpoint);
            if (i_sample < setpoint && duty != '1) begin
                duty <= duty + 1'b1;
            end else if (i_sample > setpoint && duty != '0) begin
                duty <= duty - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            pwm_cnt <= '0;
            o_pwm   <= 1'b0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
            o_pwm   <= (pwm_cnt < duty);
        end
    end

    a_duty_no_wrap: assert property (@(posedge clk) disable iff (i_reset)
        (duty == '0 |=> duty != '1) and (duty == '1 |=> duty != '0));

endmodule

`default_nettype wire

// ==== hex_dump_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module hex_dump_tx
    import dual_sd_adc_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                i_reset,
    input  wire logic [SAMPLE_W-1:0] i_sample0,
    input  wire logic [SAMPLE_W-1:0] i_sample1,
    input  wire logic                i_sample_stb,
    output logic                     o_uart_tx
);

    logic [SAMPLE_W-1:0]             s0;
    logic [SAMPLE_W-1:0]             s1;
    logic                            busy;
    logic [2:0]                      char_idx;
    logic [3:0]                      bit_idx;
    logic [$clog2(CLKS_PER_BIT)-1:0] clk_cnt;
    logic [8:0]                      tx_rest;
    logic                            bit_end;

    function automatic logic [7:0] hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + {4'h0, nib};
        end
        return 8'h37 + {4'h0, nib};
    endfunction

    // Character n of a line: two digits per channel, then line feed.
    function automatic logic [7:0] line_char(input logic [2:0] idx,
                                             input logic [SAMPLE_W-1:0] a,
                                             input logic [SAMPLE_W-1:0] b);
        case (idx)
            3'd0:    return hex_char(a[SAMPLE_W-1 -: 4]);
            3'd1:    return hex_char(a[3:0]);
            3'd2:    return hex_char(b[SAMPLE_W-1 -: 4]);
            3'd3:    return hex_char(b[3:0]);
            default: return 8'h0A;
        endcase
    endfunction

    assign bit_end = (clk_cnt == $clog2(CLKS_PER_BIT)'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (i_reset) begin
            busy      <= 1'b0;
            o_uart_tx <= 1'b1;
            char_idx  <= '0;
            bit_idx   <= '0;
            clk_cnt   <= '0;
        end else if (!busy) begin
            if (i_sample_stb) begin
                busy      <= 1'b1;
                o_uart_tx <= 1'b0;
                char_idx  <= '0;
                bit_idx   <= '0;
                clk_cnt   <= '0;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
            if (bit_end) begin
                clk_cnt <= '0;
                if (bit_idx != 4'd9) begin
                    bit_idx   <= bit_idx + 1'b1;
                    o_uart_tx <= tx_rest[0];
                end else if (char_idx == 3'(UART_CHARS - 1)) begin
                    busy      <= 1'b0;
                    o_uart_tx <= 1'b1;
                end else begin
                    char_idx  <= char_idx + 1'b1;
                    bit_idx   <= '0;
                    o_uart_tx <= 1'b0;
                end
            end
        end
    end

    // Data bits LSB first, then the stop bit; start bit goes out directly.
    always_ff @(posedge clk) begin
        if (!busy && i_sample_stb) begin
            s0      <= i_sample0;
            s1      <= i_sample1;
            tx_rest <= {1'b1, line_char(3'd0, i_sample0, i_sample1)};
        end else if (busy && bit_end) begin
            if (bit_idx != 4'd9) begin
                tx_rest <= {1'b1, tx_rest[8:1]};
            end else begin
                tx_rest <= {1'b1, line_char(char_idx + 1'b1, s0, s1)};
            end
        end
    end

    a_idle_high: assert property (@(posedge clk) disable iff (i_reset)
        !busy |-> o_uart_tx);

endmodule

`default_nettype wire

// ==== dual_sd_adc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dual_sd_adc_top
    import dual_sd_adc_pkg::*;
(
    input  wire logic clk,
    input  wire logic i_reset,
    input  wire logic i_lvds0,
    input  wire logic i_lvds1,
    input  wire logic i_spi_sck,
    input  wire logic i_spi_cs_n,
    input  wire logic i_spi_mosi,
    output logic      o_comp0,
    output logic      o_comp1,
    output logic      o_spi_miso,
    output logic      o_pwm,
    output logic      o_locked,
    output logic      o_uart_tx
);

    logic [SAMPLE_W-1:0] sample0;
    logic [SAMPLE_W-1:0] sample1;
    logic                sample0_stb;
    logic [SPI_BITS-1:0] setpoint;
    logic                setpoint_stb;

    // Both channels run off the same reset, so their strobes line up.
    sd_digitizer u_dig0 (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_lvds       (i_lvds0),
        .o_comp       (o_comp0),
        .o_sample     (sample0),
        .o_sample_stb (sample0_stb)
    );

    sd_digitizer u_dig1 (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_lvds       (i_lvds1),
        .o_comp       (o_comp1),
        .o_sample     (sample1),
        .o_sample_stb ()
    );

    spi_setpoint_rx u_spi (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_spi_sck      (i_spi_sck),
        .i_spi_cs_n     (i_spi_cs_n),
        .i_spi_mosi     (i_spi_mosi),
        .o_spi_miso     (o_spi_miso),
        .o_setpoint     (setpoint),
        .o_setpoint_stb (setpoint_stb)
    );

    pwm_tracker u_pwm (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_setpoint     (setpoint),
        .i_setpoint_stb (setpoint_stb),
        .i_sample       (sample0),
        .i_sample_stb   (sample0_stb),
        .o_pwm          (o_pwm),
        .o_locked       (o_locked)
    );

    hex_dump_tx u_dump (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_sample0    (sample0),
        .i_sample1    (sample1),
        .i_sample_stb (sample0_stb),
        .o_uart_tx    (o_uart_tx)
    );

endmodule

`default_nettype wire

// ==== dual_sd_adc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dual_sd_adc_tb
    import dual_sd_adc_pkg::*;
();

    localparam int SEED           = 93;
    localparam int RESET_CYCLES   = 8;
    localparam int NUM_WIN        = 40;
    localparam int N_SPI          = 3;
    localparam int SPI_HALF       = 8;
    localparam int FIRST_SPI_WIN  = 5;
    localparam int SPI_WIN_STEP   = 10;
    localparam int SAT_WIN        = 7;
    localparam int N_LOCK_WIN     = 5;
    // 40 windows of 256 clocks plus reset and the last dump line, with margin.
    localparam int TIMEOUT_CYCLES = 20000;

    localparam int T_RESET = 0;
    localparam int T_COMP  = 1;
    localparam int T_UART  = 2;
    localparam int T_SPI   = 3;
    localparam int T_PWM   = 4;
    localparam int T_LOCK  = 5;

    logic clk;
    logic i_reset;
    logic i_lvds0;
    logic i_lvds1;
    logic i_spi_sck;
    logic i_spi_cs_n;
    logic i_spi_mosi;
    logic o_comp0;
    logic o_comp1;
    logic o_spi_miso;
    logic o_pwm;
    logic o_locked;
    logic o_uart_tx;

    logic [7:0] spi_bytes [N_SPI];
    logic [7:0] m_setpoint;
    logic [7:0] exp0 [NUM_WIN + 8];
    logic [7:0] exp1 [NUM_WIN + 8];
    int         win_done = 0;
    int         lines_done = 0;
    int         n_locked = 0;
    int         checks [6];
    int         errors [6];

    initial clk = 1'b0;
    always #2 clk = ~clk;

    dual_sd_adc_top dut (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_lvds0    (i_lvds0),
        .i_lvds1    (i_lvds1),
        .i_spi_sck  (i_spi_sck),
        .i_spi_cs_n (i_spi_cs_n),
        .i_spi_mosi (i_spi_mosi),
        .o_comp0    (o_comp0),
        .o_comp1    (o_comp1),
        .o_spi_miso (o_spi_miso),
        .o_pwm      (o_pwm),
        .o_locked   (o_locked),
        .o_uart_tx  (o_uart_tx)
    );

    task automatic check(input int id, input bit ok, input string msg);
        checks[id]++;
        assert (ok) else begin
            $display("Fail %0t: %s", $time, msg);
            errors[id]++;
        end
    endtask

    task automatic report(input int id, input string name);
        $display("%-10s %0d checks, %0d errors", name, checks[id], errors[id]);
    endtask

    function automatic logic [7:0] hex_ascii(input logic [3:0] nib);
        string digits;
        digits = "0123456789ABCDEF";
        return digits[nib];
    endfunction

    // Setpoint in force when window w ends; transfers happen inside their window.
    function automatic int setpoint_at(input int w);
        int idx;
        if (w < FIRST_SPI_WIN) begin
            return 0;
        end
        idx = (w - FIRST_SPI_WIN) / SPI_WIN_STEP;
        if (idx > N_SPI - 1) begin
            idx = N_SPI - 1;
        end
        return int'(spi_bytes[idx]);
    endfunction

    function automatic bit lock_window(input int w);
        return w == 2 || w == 9 || w == 12 || w == 20 || w == 33;
    endfunction

    // SPI mode 0, MSB first; MISO is read at each rising SCK.
    task automatic spi_transfer(input logic [7:0] tx, output logic [7:0] echo);
        @(posedge clk);
        i_spi_cs_n <= 1'b0;
        i_spi_mosi <= tx[7];
        repeat (SPI_HALF) @(posedge clk);
        for (int i = 7; i >= 0; i--) begin
            i_spi_sck <= 1'b1;
            echo[i] = o_spi_miso;
            repeat (SPI_HALF) @(posedge clk);
            i_spi_sck <= 1'b0;
            if (i > 0) begin
                i_spi_mosi <= tx[i - 1];
            end
            repeat (SPI_HALF) @(posedge clk);
        end
        i_spi_cs_n <= 1'b1;
        repeat (SPI_HALF) @(posedge clk);
    endtask

    // Comparator windows start two edges early to cover the synchronizer.
    initial begin : lvds_drive
        int d0;
        int d1;
        int t0;
        repeat (RESET_CYCLES - 2) @(posedge clk);
        for (int w = 0; w < NUM_WIN; w++) begin
            d0 = $urandom_range(256);
            d1 = $urandom_range(256);
            t0 = setpoint_at(w);
            for (int k = 0; k < WINDOW_LEN; k++) begin
                if (w == SAT_WIN) begin
                    i_lvds0 <= 1'b1;
                    i_lvds1 <= 1'b1;
                end else begin
                    i_lvds0 <= lock_window(w) ? (k < t0) : ($urandom_range(255) < d0);
                    i_lvds1 <= ($urandom_range(255) < d1);
                end
                @(posedge clk);
            end
        end
        i_lvds0 <= 1'b0;
        i_lvds1 <= 1'b0;
    end

    // Reference model, evaluated between clock edges.
    initial begin : model
        logic [1:0] hist0;
        logic [1:0] hist1;
        logic [7:0] pcnt;
        logic       m_pwm;
        logic       m_locked;
        int         acc0;
        int         acc1;
        int         wcnt;
        int         duty;
        int         pending;
        int         s0;
        hist0 = '0;
        hist1 = '0;
        pcnt = '0;
        m_pwm = 1'b0;
        m_locked = 1'b0;
        acc0 = 0;
        acc1 = 0;
        wcnt = 0;
        duty = 0;
        pending = 0;
        forever begin
            @(negedge clk);
            if (!i_reset) begin
                check(T_COMP, o_comp0 === hist0[1] && o_comp1 === hist1[1],
                      $sformatf("o_comp got %b%b expected %b%b",
                                o_comp0, o_comp1, hist0[1], hist1[1]));
                check(T_PWM, o_pwm === m_pwm,
                      $sformatf("o_pwm got %b expected %b, duty %0d", o_pwm, m_pwm, duty));
                // Lock and duty show two cycles after the last sample of a window.
                if (pending > 0) begin
                    pending--;
                    if (pending == 0) begin
                        s0 = int'(exp0[win_done - 1]);
                        m_locked = (s0 == int'(m_setpoint));
                        if (s0 < int'(m_setpoint) && duty < 255) begin
                            duty++;
                        end else if (s0 > int'(m_setpoint) && duty > 0) begin
                            duty--;
                        end
                        check(T_LOCK, o_locked === m_locked,
                              $sformatf("o_locked got %b expected %b, sample %0d setpoint %0d",
                                        o_locked, m_locked, s0, m_setpoint));
                        if (o_locked === 1'b1) begin
                            n_locked++;
                        end
                    end
                end
                acc0 += int'(hist0[1]);
                acc1 += int'(hist1[1]);
                wcnt++;
                if (wcnt == WINDOW_LEN) begin
                    exp0[win_done] = (acc0 > 255) ? 8'hFF : 8'(acc0);
                    exp1[win_done] = (acc1 > 255) ? 8'hFF : 8'(acc1);
                    win_done++;
                    acc0 = 0;
                    acc1 = 0;
                    wcnt = 0;
                    pending = 2;
                end
                m_pwm = (pcnt < 8'(duty));
                pcnt = pcnt + 8'd1;
            end
            hist0 = {hist0[0], i_lvds0};
            hist1 = {hist1[0], i_lvds1};
        end
    end

    // 8N1 receiver, sampling near the middle of each bit.
    initial begin : uart_rx
        logic [7:0]  ch;
        logic [39:0] line;
        logic [39:0] want;
        int          n_chars;
        n_chars = 0;
        line = '0;
        forever begin
            @(negedge clk);
            if (!i_reset && o_uart_tx === 1'b0) begin
                @(negedge clk);
                for (int b = 0; b < 8; b++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    ch[b] = o_uart_tx;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                check(T_UART, o_uart_tx === 1'b1, "UART stop bit is low");
                line = {line[31:0], ch};
                n_chars++;
                if (n_chars == UART_CHARS) begin
                    if (lines_done < win_done) begin
                        want = {hex_ascii(exp0[lines_done][7:4]), hex_ascii(exp0[lines_done][3:0]),
                                hex_ascii(exp1[lines_done][7:4]), hex_ascii(exp1[lines_done][3:0]),
                                8'h0A};
                        check(T_UART, line === want,
                              $sformatf("line %0d got %h expected %h", lines_done, line, want));
                    end else begin
                        check(T_UART, 1'b0, "a UART line arrived before its window ended");
                    end
                    lines_done++;
                    n_chars = 0;
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish");
        $display("TEST FAIL");
        $finish;
    end

    initial begin : main
        logic [7:0] echo;
        logic [7:0] prev;
        int         total_checks;
        int         total_errors;
        void'($urandom(SEED));
        for (int i = 0; i < N_SPI; i++) begin
            spi_bytes[i] = 8'($urandom_range(255));
        end
        m_setpoint = '0;
        i_reset <= 1'b1;
        i_lvds0 <= 1'b0;
        i_lvds1 <= 1'b0;
        i_spi_sck <= 1'b0;
        i_spi_cs_n <= 1'b1;
        i_spi_mosi <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        i_reset <= 1'b0;
        @(negedge clk);
        check(T_RESET, o_uart_tx === 1'b1 && o_pwm === 1'b0 && o_locked === 1'b0
              && o_spi_miso === 1'b0,
              $sformatf("after reset tx %b pwm %b locked %b miso %b",
                        o_uart_tx, o_pwm, o_locked, o_spi_miso));
        report(T_RESET, "reset");

        prev = '0;
        for (int i = 0; i < N_SPI; i++) begin
            wait (win_done >= FIRST_SPI_WIN + SPI_WIN_STEP * i);
            spi_transfer(spi_bytes[i], echo);
            check(T_SPI, echo === prev,
                  $sformatf("SPI echo got %h expected %h", echo, prev));
            prev = spi_bytes[i];
            m_setpoint = spi_bytes[i];
        end
        report(T_SPI, "spi_echo");

        wait (lines_done == NUM_WIN);
        @(negedge clk);
        check(T_LOCK, n_locked >= N_LOCK_WIN,
              $sformatf("lock seen in %0d windows, expected at least %0d", n_locked, N_LOCK_WIN));
        report(T_COMP, "comp_sync");
        report(T_UART, "uart_dump");
        report(T_PWM, "pwm");
        report(T_LOCK, "lock");

        total_checks = 0;
        total_errors = 0;
        for (int i = 0; i < 6; i++) begin
            total_checks += checks[i];
            total_errors += errors[i];
        end
        $display("total %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dual_sd_adc.f ====
dual_sd_adc_pkg.sv
sd_digitizer.sv
spi_setpoint_rx.sv
pwm_tracker.sv
hex_dump_tx.sv
dual_sd_adc_top.sv
dual_sd_adc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the dual_sd_adc testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f dual_sd_adc.f \
    --top-module dual_sd_adc_tb \
    -o sim_dual_sd_adc

./obj_dir/sim_dual_sd_adc | tee sim.log

if grep -qx "TEST PASS" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1
